// ==== hw/rv32v_mem_params.svh ====
// ==============================
// Size macros for the RV32V memory stage
// Data width, vector length and lane count
// ==============================

`ifndef RV32V_MEM_PARAMS_SVH
`define RV32V_MEM_PARAMS_SVH

// Scalar data and address width
`define RV32V_XLEN 32

// Vector register length in bytes
`define RV32V_VLENB 16

// Element lanes carried per packet
`define RV32V_LANES 2

`endif

// ==== hw/rv32v_mem_pkg.sv ====
// ==============================
// Enums and packed structs shared by the
// RV32V memory stage and its config block
// ==============================

`include "rv32v_mem_params.svh"

package rv32v_mem_pkg;

  typedef enum logic [1:0] {
    EEW8  = 2'd0,
    EEW16 = 2'd1,
    EEW32 = 2'd2
  } eew_t;

  typedef enum logic [2:0] {
    LMUL1 = 3'd0,
    LMUL2 = 3'd1,
    LMUL4 = 3'd2,
    LMUL8 = 3'd3
  } lmul_t;

  typedef enum logic [1:0] {
    OP_ALU    = 2'd0,
    OP_LOAD   = 2'd1,
    OP_STORE  = 2'd2,
    OP_CONFIG = 2'd3
  } mem_op_t;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    LANE0 = 2'd1,
    LANE1 = 2'd2,
    DONE  = 2'd3
  } sched_state_t;

  // next_vtype layout: sew in [2:0], lmul in [5:3]
  typedef struct packed {
    mem_op_t                                  op;
    eew_t                                     eew;
    logic [`RV32V_LANES-1:0][`RV32V_XLEN-1:0] aluresult;
    logic [`RV32V_LANES-1:0][`RV32V_XLEN-1:0] storedata;
    logic [`RV32V_LANES-1:0]                  lane_wen;
    logic [4:0]                               vd;
    logic [7:0]                               ls_idx;
    logic [`RV32V_XLEN-1:0]                   avl;
    logic [7:0]                               next_vtype;
  } ex_mem_t;

  typedef struct packed {
    logic                   ren;
    logic                   wen;
    logic [3:0]             byte_ena;
    logic [`RV32V_XLEN-1:0] addr;
    logic [`RV32V_XLEN-1:0] wdata;
  } dcache_req_t;

  typedef struct packed {
    logic                   dhit;
    logic [`RV32V_XLEN-1:0] dmemload;
  } dcache_rsp_t;

  typedef struct packed {
    logic [`RV32V_LANES-1:0][`RV32V_XLEN-1:0] wdat;
    logic [`RV32V_LANES-1:0]                  lane_wen;
    logic [4:0]                               vd;
    eew_t                                     eew;
    logic [`RV32V_XLEN-1:0]                   vl;
    eew_t                                     sew;
    lmul_t                                    lmul;
  } mem_wb_t;

  typedef struct packed {
    logic [`RV32V_XLEN-1:0] vl;
    eew_t                   sew;
    lmul_t                  lmul;
    logic [`RV32V_XLEN-1:0] vstart;
  } vcfg_t;

endpackage

// ==== hw/rv32v_vector_csr.sv ====
// ==============================
// Vector configuration registers
// vl, vtype (sew/lmul) and vstart
// ==============================

`timescale 1ns/10ps

`include "rv32v_mem_params.svh"

module rv32v_vector_csr (
  input  logic                   CLK,
  input  logic                   nRST,
  input  rv32v_mem_pkg::ex_mem_t ex_in,
  input  logic                   ex_valid,
  input  logic [1:0]             elem_done,
  output rv32v_mem_pkg::vcfg_t   cfg
);
  import rv32v_mem_pkg::*;

  logic                   cfg_wr;
  eew_t                   sew_in;
  lmul_t                  lmul_in;
  logic [`RV32V_XLEN-1:0] elem_cnt;
  logic [`RV32V_XLEN-1:0] vlmax;
  logic [`RV32V_XLEN-1:0] vl_new;
  logic [`RV32V_XLEN-1:0] done_cnt;

  assign cfg_wr  = ex_valid && (ex_in.op == OP_CONFIG);
  assign sew_in  = eew_t'(ex_in.next_vtype[1:0]);
  assign lmul_in = lmul_t'(ex_in.next_vtype[5:3]);

  // VLEN / SEW elements per register, then grouped by lmul
  assign elem_cnt  = (`RV32V_XLEN'(`RV32V_VLENB) << 3) >> (3'd3 + {1'b0, sew_in});
  assign vlmax     = elem_cnt << lmul_in;
  assign vl_new    = (ex_in.avl < vlmax) ? ex_in.avl : vlmax;

  // Elements finished by the scheduler this cycle
  assign done_cnt = `RV32V_XLEN'(elem_done[0]) + `RV32V_XLEN'(elem_done[1]);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cfg <= '0;
    end else if (cfg_wr) begin
      cfg.vl     <= vl_new;
      cfg.sew    <= sew_in;
      cfg.lmul   <= lmul_in;
      cfg.vstart <= '0;
    end else begin
      cfg.vstart <= cfg.vstart + done_cnt;
    end
  end

endmodule

// ==== hw/rv32v_address_scheduler.sv ====
// ==============================
// Address scheduler
// Serializes the active lanes of a vector
// load/store onto one data cache port
// ==============================

`timescale 1ns/10ps

`include "rv32v_mem_params.svh"

module rv32v_address_scheduler (
  input  logic                       CLK,
  input  logic                       nRST,
  input  logic                       start,
  input  rv32v_mem_pkg::ex_mem_t     pkt,
  input  logic [`RV32V_XLEN-1:0]     vl,
  input  logic                       flush,
  output rv32v_mem_pkg::dcache_req_t dc_req,
  input  logic                       dhit,
  output logic [1:0]                 arrived,
  output logic                       done,
  output logic                       busy,
  output logic                       exception
);
  import rv32v_mem_pkg::*;

  sched_state_t           state;
  sched_state_t           next_state;
  ex_mem_t                pkt_q;
  logic                   en1_q;
  logic                   exc_q;
  logic                   is_mem;
  logic                   accept;
  logic [1:0]             lane_en;
  logic [1:0]             misaligned;
  logic                   lane_sel;
  logic                   active;
  logic [`RV32V_XLEN-1:0] cur_addr;
  logic [1:0]             boff;

  // Element address must be a multiple of the element size
  function automatic logic is_aligned(input eew_t eew, input logic [1:0] lo);
    logic ok;
    case (eew)
      EEW16:   ok = (lo[0] == 1'b0);
      EEW32:   ok = (lo == 2'b00);
      default: ok = 1'b1;
    endcase
    return ok;
  endfunction

  assign is_mem = start && ((pkt.op == OP_LOAD) || (pkt.op == OP_STORE));
  assign accept = is_mem && (state == IDLE) && !flush;

  // Lane 1 drops out once its element index reaches vl
  assign lane_en[0] = pkt.lane_wen[0];
  assign lane_en[1] = pkt.lane_wen[1] &&
                      ((`RV32V_XLEN'(pkt.ls_idx) + `RV32V_XLEN'(1)) < vl);

  assign misaligned[0] = lane_en[0] && !is_aligned(pkt.eew, pkt.aluresult[0][1:0]);
  assign misaligned[1] = lane_en[1] && !is_aligned(pkt.eew, pkt.aluresult[1][1:0]);

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (accept && (misaligned == 2'b00)) begin
          if (lane_en[0]) begin
            next_state = LANE0;
          end else if (lane_en[1]) begin
            next_state = LANE1;
          end else begin
            // Nothing to access, finish straight away
            next_state = DONE;
          end
        end
      end
      LANE0: begin
        if (dhit) begin
          next_state = en1_q ? LANE1 : IDLE;
        end
      end
      LANE1: begin
        if (dhit) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      en1_q <= 1'b0;
      exc_q <= 1'b0;
    end else begin
      state <= flush ? IDLE : next_state;
      exc_q <= accept && (misaligned != 2'b00);
      if (accept) begin
        en1_q <= lane_en[1];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      pkt_q <= pkt;
    end
  end

  // Request stays put until dhit, then moves on at the next edge
  assign active   = (state == LANE0) || (state == LANE1);
  assign lane_sel = (state == LANE1);
  assign cur_addr = pkt_q.aluresult[lane_sel];
  assign boff     = cur_addr[1:0];

  assign dc_req.ren   = active && (pkt_q.op == OP_LOAD);
  assign dc_req.wen   = active && (pkt_q.op == OP_STORE);
  assign dc_req.addr  = {cur_addr[`RV32V_XLEN-1:2], 2'b00};
  assign dc_req.wdata = pkt_q.storedata[lane_sel] << {boff, 3'b000};

  always_comb begin
    case (pkt_q.eew)
      EEW8:    dc_req.byte_ena = 4'b0001 << boff;
      EEW16:   dc_req.byte_ena = 4'b0011 << boff;
      default: dc_req.byte_ena = 4'b1111;
    endcase
  end

  assign arrived[0] = (state == LANE0) && dhit;
  assign arrived[1] = (state == LANE1) && dhit;

  // Done on the hit of the last active lane, or with no lanes at all
  assign done = (arrived[0] && !en1_q) || arrived[1] || (state == DONE);

  assign busy      = (state != IDLE);
  assign exception = exc_q;

endmodule

// ==== hw/rv32v_memory_stage.sv ====
// ==============================
// RV32V memory stage
// Load buffer, lane extraction and
// writeback latch around the scheduler
// ==============================

`timescale 1ns/10ps

`include "rv32v_mem_params.svh"

module rv32v_memory_stage (
  input  logic                       CLK,
  input  logic                       nRST,
  input  rv32v_mem_pkg::ex_mem_t     ex_in,
  input  logic                       ex_valid,
  input  logic                       flush,
  input  logic [`RV32V_XLEN-1:0]     vl,
  input  rv32v_mem_pkg::vcfg_t       cfg,
  output rv32v_mem_pkg::dcache_req_t dc_req,
  input  rv32v_mem_pkg::dcache_rsp_t dc_rsp,
  output rv32v_mem_pkg::mem_wb_t     wb_out,
  output logic                       wb_valid,
  output logic                       busy,
  output logic                       exception,
  output logic [1:0]                 elem_done
);
  import rv32v_mem_pkg::*;

  ex_mem_t                                  hold_q;
  ex_mem_t                                  src;
  mem_wb_t                                  wb_next;
  logic                                     cfg_pend;
  logic [1:0]                               got_q;
  logic [1:0]                               arrived;
  logic                                     done;
  logic                                     sched_busy;
  logic [`RV32V_XLEN-1:0]                   load_buf;
  logic [`RV32V_XLEN-1:0]                   lane0_word;
  logic [`RV32V_LANES-1:0][`RV32V_XLEN-1:0] load_val;
  logic                                     alu_now;
  logic                                     is_load;
  logic                                     wb_load;

  // Align the element to bit 0 and zero-extend from eew
  function automatic logic [`RV32V_XLEN-1:0] extract(
    input logic [`RV32V_XLEN-1:0] word,
    input logic [1:0]             boff,
    input eew_t                   eew
  );
    logic [`RV32V_XLEN-1:0] s;
    s = word >> {boff, 3'b000};
    case (eew)
      EEW8:    return {24'd0, s[7:0]};
      EEW16:   return {16'd0, s[15:0]};
      default: return s;
    endcase
  endfunction

  rv32v_address_scheduler sched0 (
    .CLK       (CLK),
    .nRST      (nRST),
    .start     (ex_valid),
    .pkt       (ex_in),
    .vl        (vl),
    .flush     (flush),
    .dc_req    (dc_req),
    .dhit      (dc_rsp.dhit),
    .arrived   (arrived),
    .done      (done),
    .busy      (sched_busy),
    .exception (exception)
  );

  // Holding register for the packet in flight
  always_ff @(posedge CLK) begin
    if (ex_valid) begin
      hold_q <= ex_in;
    end
  end

  // Lane 0 word kept until the packet completes
  always_ff @(posedge CLK) begin
    if (arrived[0]) begin
      load_buf <= dc_rsp.dmemload;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cfg_pend <= 1'b0;
      got_q    <= 2'b00;
    end else begin
      cfg_pend <= ex_valid && (ex_in.op == OP_CONFIG) && !flush;
      if (ex_valid) begin
        got_q <= 2'b00;
      end else begin
        got_q <= got_q | arrived;
      end
    end
  end

  // Lane 0 bypasses the buffer when it is the only lane
  assign lane0_word  = arrived[0] ? dc_rsp.dmemload : load_buf;
  assign load_val[0] = extract(lane0_word, hold_q.aluresult[0][1:0], hold_q.eew);
  assign load_val[1] = extract(dc_rsp.dmemload, hold_q.aluresult[1][1:0], hold_q.eew);

  assign alu_now = ex_valid && (ex_in.op == OP_ALU);
  assign is_load = !alu_now && (hold_q.op == OP_LOAD);
  assign wb_load = alu_now || cfg_pend || done;
  assign src     = alu_now ? ex_in : hold_q;

  always_comb begin
    wb_next.wdat = is_load ? load_val : src.aluresult;
    if (alu_now) begin
      wb_next.lane_wen = ex_in.lane_wen;
    end else if (is_load) begin
      wb_next.lane_wen = got_q | arrived;
    end else begin
      // Stores and config writes update no vector register
      wb_next.lane_wen = 2'b00;
    end
    wb_next.vd   = src.vd;
    wb_next.eew  = src.eew;
    wb_next.vl   = cfg.vl;
    wb_next.sew  = cfg.sew;
    wb_next.lmul = cfg.lmul;
  end

  // Writeback latch
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= wb_load && !flush;
    end
  end

  always_ff @(posedge CLK) begin
    if (wb_load) begin
      wb_out <= wb_next;
    end
  end

  // Config writeback occupies the latch for one extra cycle
  assign busy      = sched_busy || cfg_pend;
  assign elem_done = arrived;

endmodule

// ==== hw/rv32v_memory_top.sv ====
// ==============================
// RV32V memory stage top
// Config block beside the memory stage
// ==============================

`timescale 1ns/10ps

module rv32v_memory_top (
  input  logic                       CLK,
  input  logic                       nRST,
  input  rv32v_mem_pkg::ex_mem_t     ex_in,
  input  logic                       ex_valid,
  input  logic                       flush,
  input  rv32v_mem_pkg::dcache_rsp_t dc_rsp,
  output rv32v_mem_pkg::dcache_req_t dc_req,
  output rv32v_mem_pkg::mem_wb_t     wb_out,
  output logic                       wb_valid,
  output logic                       busy,
  output logic                       exception,
  output rv32v_mem_pkg::vcfg_t       cfg
);

  logic [1:0] elem_done;

  rv32v_vector_csr csr0 (
    .CLK       (CLK),
    .nRST      (nRST),
    .ex_in     (ex_in),
    .ex_valid  (ex_valid),
    .elem_done (elem_done),
    .cfg       (cfg)
  );

  rv32v_memory_stage stage0 (
    .CLK       (CLK),
    .nRST      (nRST),
    .ex_in     (ex_in),
    .ex_valid  (ex_valid),
    .flush     (flush),
    .vl        (cfg.vl),
    .cfg       (cfg),
    .dc_req    (dc_req),
    .dc_rsp    (dc_rsp),
    .wb_out    (wb_out),
    .wb_valid  (wb_valid),
    .busy      (busy),
    .exception (exception),
    .elem_done (elem_done)
  );

endmodule

// ==== verification/dcache_model.sv ====
// ==============================
// Data cache model for the testbench
// Word memory with a per-packet hit delay
// ==============================

`timescale 1ns/10ps

module dcache_model (
  input  logic                       CLK,
  input  logic                       nRST,
  input  rv32v_mem_pkg::dcache_req_t req,
  input  logic [2:0]                 delay,
  output rv32v_mem_pkg::dcache_rsp_t rsp
);
  import rv32v_mem_pkg::*;

  logic [31:0] mem [0:63];
  logic [2:0]  wait_cnt;
  logic        active;
  logic [5:0]  idx;

  // Fill pattern spreads every address bit over the word
  initial begin : fill
    int i;
    for (i = 0; i < 64; i++) begin
      mem[i] = ((32'(i) << 2) * 32'h9E3779B1) ^ 32'h5A5A0F0F;
    end
  end

  assign active = req.ren || req.wen;
  assign idx    = req.addr[7:2];

  // Hit once the request has waited delay cycles
  assign rsp.dhit     = active && (wait_cnt == delay);
  assign rsp.dmemload = mem[idx];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wait_cnt <= '0;
    end else if (!active || rsp.dhit) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 3'd1;
    end
  end

  // Byte-enabled write on the hit cycle
  always @(posedge CLK) begin : write_port
    int b;
    if (rsp.dhit && req.wen) begin
      for (b = 0; b < 4; b++) begin
        if (req.byte_ena[b]) begin
          mem[idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
        end
      end
    end
  end

endmodule

// ==== verification/tb_rv32v_memory.sv ====
// ==============================
// Testbench for the RV32V memory stage
// Stimulus, reference model and assertions
// ==============================

`timescale 1ns/10ps

`include "rv32v_mem_params.svh"

module tb_rv32v_memory;
  import rv32v_mem_pkg::*;

  localparam int N_PKTS      = 27;
  localparam int WATCHDOG_NS = N_PKTS * 200 * 20;

  logic             CLK;
  logic             nRST;
  ex_mem_t          ex_in;
  logic             ex_valid;
  logic             flush;
  dcache_req_t      dc_req;
  dcache_rsp_t      dc_rsp;
  mem_wb_t          wb_out;
  logic             wb_valid;
  logic             busy;
  logic             exception;
  vcfg_t            cfg;
  logic [2:0]       hit_delay;
  // Reference model
  logic [31:0]      sh_mem [0:63];
  logic [31:0]      ref_vl;
  logic [31:0]      ref_vstart;
  eew_t             ref_sew;
  lmul_t            ref_lmul;
  logic [1:0][31:0] exp_wdat;
  logic [1:0]       exp_wen;
  logic [1:0]       exp_mask;
  logic [4:0]       exp_vd;
  eew_t             exp_eew;
  logic             wb_allowed;
  logic             exc_allowed;
  logic             mem_inflight;
  logic [1:0]       lane_ok;
  logic [1:0][31:0] lane_addr;
  logic [15:0]      lfsr;
  int               errors;
  int               timeouts;
  logic             alu_fire;
  logic             cfg_fire;
  logic             req_on;
  logic             addr_ok;
  logic             wb_match;

  rv32v_memory_top dut0 (
    .CLK(CLK), .nRST(nRST), .ex_in(ex_in), .ex_valid(ex_valid), .flush(flush),
    .dc_rsp(dc_rsp), .dc_req(dc_req), .wb_out(wb_out), .wb_valid(wb_valid),
    .busy(busy), .exception(exception), .cfg(cfg)
  );

  dcache_model dcache0 (
    .CLK(CLK), .nRST(nRST), .req(dc_req), .delay(hit_delay), .rsp(dc_rsp)
  );

  initial begin
    CLK = 1'b0;
    forever begin
      #10 CLK = ~CLK;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the test sequence finished");
    $display("Simulation failed");
    $finish;
  end

  task automatic log_error(input string msg);
    errors++;
    $display("Error %0t: %s", $time, msg);
  endtask

  // Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] put_elem(input logic [31:0] word, input logic [31:0] data,
                                           input logic [1:0] off, input logic [1:0] eew);
    logic [31:0] w;
    int          b;
    w = word;
    for (b = 0; b < (1 << eew); b++) begin
      w[(int'(off) + b)*8 +: 8] = data[b*8 +: 8];
    end
    return w;
  endfunction

  // Element bytes moved to bit 0, upper bits zero
  function automatic logic [31:0] get_elem(input logic [31:0] word, input logic [1:0] off,
                                           input logic [1:0] eew);
    logic [31:0] v;
    int          b;
    v = '0;
    for (b = 0; b < (1 << eew); b++) begin
      v[b*8 +: 8] = word[(int'(off) + b)*8 +: 8];
    end
    return v;
  endfunction

  function automatic logic [31:0] rand_addr(input logic [5:0] word, input logic [1:0] eew);
    logic [1:0] off;
    off = 2'(take_bits(2));
    if (eew == 2'd1) off[0] = 1'b0;
    if (eew == 2'd2) off = 2'b00;
    return {24'd0, word, off};
  endfunction

  assign alu_fire = ex_valid && (ex_in.op == OP_ALU) && !flush;
  assign cfg_fire = ex_valid && (ex_in.op == OP_CONFIG);
  assign req_on   = dc_req.ren || dc_req.wen;
  assign addr_ok  = (lane_ok[0] && (dc_req.addr == {lane_addr[0][31:2], 2'b00})) ||
                    (lane_ok[1] && (dc_req.addr == {lane_addr[1][31:2], 2'b00}));
  assign wb_match = wb_allowed && (wb_out.lane_wen == exp_wen) && (wb_out.vd == exp_vd) &&
                    (wb_out.vl == ref_vl) && (cfg.vstart == ref_vstart) &&
                    (wb_out.eew == exp_eew) && (wb_out.sew == ref_sew) &&
                    (wb_out.lmul == ref_lmul) &&
                    (!exp_mask[0] || (wb_out.wdat[0] == exp_wdat[0])) &&
                    (!exp_mask[1] || (wb_out.wdat[1] == exp_wdat[1]));

  a_wb: assert property (@(posedge CLK) disable iff (!nRST) wb_valid |-> wb_match)
    else log_error("writeback packet differs from the reference");
  a_alu: assert property (@(posedge CLK) disable iff (!nRST) $past(alu_fire) |-> wb_valid)
    else log_error("ALU writeback not one cycle after ex_valid");
  a_cfg: assert property (@(posedge CLK) disable iff (!nRST) $past(cfg_fire) |->
      ((cfg.vl == ref_vl) && (cfg.sew == ref_sew) && (cfg.lmul == ref_lmul) &&
       (cfg.vstart == '0)))
    else log_error("configuration registers differ from the reference");
  a_cfg_wb: assert property (@(posedge CLK) disable iff (!nRST) $past(cfg_fire, 2) |-> wb_valid)
    else log_error("config writeback missing two cycles after ex_valid");
  a_busy: assert property (@(posedge CLK) disable iff (!nRST)
      (mem_inflight && !ex_valid && !wb_valid) |-> busy)
    else log_error("busy dropped before the writeback");
  a_hold: assert property (@(posedge CLK) disable iff (!nRST)
      $past(req_on && !dc_rsp.dhit && !flush) |-> (dc_req == $past(dc_req)))
    else log_error("cache request changed before dhit");
  a_addr: assert property (@(posedge CLK) disable iff (!nRST) req_on |-> addr_ok)
    else log_error("cache request for an inactive lane");
  a_exc: assert property (@(posedge CLK) disable iff (!nRST) exception |-> exc_allowed)
    else log_error("unexpected exception");

  // Busy tracking starts in the same cycle as ex_valid
  task automatic issue(input ex_mem_t pkt, input logic track_busy);
    @(negedge CLK);
    ex_in        = pkt;
    ex_valid     = 1'b1;
    mem_inflight = track_busy;
    @(negedge CLK);
    ex_valid = 1'b0;
  endtask

  // Waits for wb_valid or exception, then clears the expectations
  task automatic wait_result(input logic want_exc);
    int n;
    n = 0;
    while ((want_exc ? !exception : !wb_valid) && (n < 200)) begin
      @(negedge CLK);
      n++;
    end
    if (n >= 200) begin
      timeouts++;
      $display("Timed out at %0t waiting for the stage to respond", $time);
    end
    @(negedge CLK);
    wb_allowed   = 1'b0;
    exc_allowed  = 1'b0;
    mem_inflight = 1'b0;
  endtask

  task automatic configure(input logic [31:0] avl, input logic [1:0] sew,
                           input logic [2:0] lmul);
    ex_mem_t     p;
    logic [31:0] vlmax;
    p            = '0;
    p.op         = OP_CONFIG;
    p.avl        = avl;
    p.next_vtype = {2'b00, lmul, 1'b0, sew};
    p.vd         = 5'(take_bits(5));
    vlmax        = ((`RV32V_VLENB * 8) / (8 << sew)) << lmul;
    ref_vl       = (avl < vlmax) ? avl : vlmax;
    ref_sew      = eew_t'(sew);
    ref_lmul     = lmul_t'(lmul);
    ref_vstart   = '0;
    exp_wen      = 2'b00;
    exp_mask     = 2'b00;
    exp_vd       = p.vd;
    exp_eew      = p.eew;
    lane_ok      = 2'b00;
    wb_allowed   = 1'b1;
    issue(p, 1'b0);
    wait_result(1'b0);
  endtask

  task automatic alu_packet();
    ex_mem_t p;
    p              = '0;
    p.op           = OP_ALU;
    p.eew          = eew_t'(2'(take_bits(2) % 3));
    p.aluresult[0] = take_bits(32);
    p.aluresult[1] = take_bits(32);
    p.lane_wen     = 2'(take_bits(2));
    p.vd           = 5'(take_bits(5));
    exp_wdat       = p.aluresult;
    exp_wen        = p.lane_wen;
    exp_mask       = 2'b11;
    exp_vd         = p.vd;
    exp_eew        = p.eew;
    lane_ok        = 2'b00;
    wb_allowed     = 1'b1;
    issue(p, 1'b0);
    wait_result(1'b0);
  endtask

  // mode 0 normal, 1 misaligned, 2 flushed while busy
  task automatic mem_access(input mem_op_t op, input logic [1:0] eew,
                            input logic [1:0][31:0] addr, input logic [1:0] wen,
                            input logic [7:0] idx, input int mode);
    ex_mem_t    p;
    logic [1:0] act;
    int         l;
    p              = '0;
    p.op           = op;
    p.eew          = eew_t'(eew);
    p.aluresult    = addr;
    p.lane_wen     = wen;
    p.ls_idx       = idx;
    p.storedata[0] = take_bits(32);
    p.storedata[1] = take_bits(32);
    p.vd           = 5'(take_bits(5));
    act[0]         = wen[0];
    act[1]         = wen[1] && ((32'(idx) + 32'd1) < ref_vl);
    hit_delay      = (mode == 2) ? 3'd7 : 3'(take_bits(3));
    for (l = 0; l < 2; l++) begin
      if (act[l] && (op == OP_STORE)) begin
        sh_mem[addr[l][7:2]] = put_elem(sh_mem[addr[l][7:2]], p.storedata[l],
                                        addr[l][1:0], eew);
      end
      exp_wdat[l] = get_elem(sh_mem[addr[l][7:2]], addr[l][1:0], eew);
    end
    exp_wen   = (op == OP_LOAD) ? act : 2'b00;
    exp_mask  = exp_wen;
    exp_vd    = p.vd;
    exp_eew   = p.eew;
    lane_addr = addr;
    if (mode == 1) begin
      lane_ok     = 2'b00;
      exc_allowed = 1'b1;
      issue(p, 1'b0);
      wait_result(1'b1);
      repeat (4) @(negedge CLK);
    end else if (mode == 2) begin
      lane_ok = act;
      issue(p, 1'b1);
      @(negedge CLK);
      flush        = 1'b1;
      mem_inflight = 1'b0;
      @(negedge CLK);
      flush = 1'b0;
      repeat (8) @(negedge CLK);
    end else begin
      lane_ok    = act;
      ref_vstart = ref_vstart + 32'(act[0]) + 32'(act[1]);
      wb_allowed = 1'b1;
      issue(p, 1'b1);
      wait_result(1'b0);
      if (op == OP_STORE) begin
        for (l = 0; l < 2; l++) begin
          assert (dcache0.mem[addr[l][7:2]] == sh_mem[addr[l][7:2]])
            else log_error("cache model word differs after the store");
        end
      end
    end
  endtask

  initial begin
    logic [1:0][31:0] a;
    logic [5:0]       w0;
    int               k;
    nRST         = 1'b0;
    ex_in        = '0;
    ex_valid     = 1'b0;
    flush        = 1'b0;
    hit_delay    = 3'd0;
    lfsr         = 16'd43;
    errors       = 0;
    timeouts     = 0;
    ref_vl       = '0;
    ref_vstart   = '0;
    ref_sew      = EEW8;
    ref_lmul     = LMUL1;
    exp_wdat     = '0;
    exp_wen      = 2'b00;
    exp_mask     = 2'b00;
    exp_vd       = '0;
    exp_eew      = EEW8;
    wb_allowed   = 1'b0;
    exc_allowed  = 1'b0;
    mem_inflight = 1'b0;
    lane_ok      = 2'b00;
    lane_addr    = '0;
    repeat (3) @(negedge CLK);
    nRST = 1'b1;
    for (k = 0; k < 64; k++) begin
      sh_mem[k] = dcache0.mem[k];
    end
    // Random configurations, then vl of 16 for the memory tests
    repeat (3) configure(32'(take_bits(5)), 2'(take_bits(2) % 3), 3'(take_bits(2)));
    configure(32'd32, 2'd0, 3'd0);
    repeat (4) alu_packet();
    for (k = 0; k < 6; k++) begin
      w0   = 6'(take_bits(6));
      a[0] = rand_addr(w0, 2'(k % 3));
      a[1] = rand_addr(w0 + 6'd1 + 6'(take_bits(5)), 2'(k % 3));
      mem_access(OP_STORE, 2'(k % 3), a, 2'b11, 8'd0, 0);
      mem_access(OP_LOAD, 2'(k % 3), a, 2'b11, 8'd0, 0);
    end
    // Lane skipping by lane_wen and by vl
    a[0] = rand_addr(6'd10, 2'd2);
    a[1] = rand_addr(6'd20, 2'd2);
    mem_access(OP_STORE, 2'd2, a, 2'b01, 8'd0, 0);
    mem_access(OP_LOAD, 2'd2, a, 2'b11, 8'd15, 0);
    mem_access(OP_LOAD, 2'd2, a, 2'b10, 8'd0, 0);
    mem_access(OP_STORE, 2'd2, a, 2'b00, 8'd0, 0);
    // New vtype while vstart is nonzero
    configure(32'd5, 2'd2, 3'd1);
    a[0] = 32'd41;
    mem_access(OP_LOAD, 2'd2, a, 2'b01, 8'd0, 1);
    a[0] = rand_addr(6'd3, 2'd2);
    a[1] = rand_addr(6'd4, 2'd2);
    mem_access(OP_LOAD, 2'd2, a, 2'b11, 8'd0, 2);
    repeat (2) @(negedge CLK);
    $display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+hw
hw/rv32v_mem_pkg.sv
hw/rv32v_vector_csr.sv
hw/rv32v_address_scheduler.sv
hw/rv32v_memory_stage.sv
hw/rv32v_memory_top.sv
verification/dcache_model.sv
verification/tb_rv32v_memory.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the RV32V memory stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rv32v_memory -f files.f

./obj_dir/Vtb_rv32v_memory > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
  echo "FAIL"
  exit 1
fi
echo "PASS"
